//--- design/core_if_pkg.sv
// Core-side definitions for the uncached data path.
// Widths of address, data and byte mask, and the memory operation encoding.
// Referenced by scoped name from the memory stage, the bypass and the L2 model.

`default_nettype none

package core_if_pkg;

  // Physical address width
  localparam int paddr_w = 40;

  // One doubleword of load or store data
  localparam int dword_w = 64;

  // Byte enables for one doubleword
  localparam int mask_w = dword_w / 8;

  // Memory operation held by the memory stage
  typedef enum logic {
    MEM_LOAD  = 1'b0,
    MEM_STORE = 1'b1
  } mem_op_e;

endpackage

`default_nettype wire

//--- design/l2_if_pkg.sv
// L2 port definitions for the uncached data path.
// Line geometry, lane selection inside a line and the request type encoding.
// Referenced by scoped name from the bypass and the L2 line model.

`default_nettype none

package l2_if_pkg;

  // One L2 line, four doubleword lanes
  localparam int line_w = 256;

  // Byte enables for a whole line
  localparam int line_mask_w = line_w / 8;

  // Byte offset inside a line
  localparam int line_ofs_w = 5;

  // Lane index, address bits 4 to 3
  localparam int lane_w = 2;

  // Request kind on the L2 port
  typedef enum logic {
    REQ_READ  = 1'b0,
    REQ_WRITE = 1'b1
  } req_type_e;

endpackage

`default_nettype wire

//--- design/mem_stage.sv
// Memory stage of the uncached data path.
// Accepts one load or store, holds it for the bypass until completion or flush,
// then registers the load data and pulses done.

`timescale 1ns/100ps
`default_nettype none

module mem_stage (
  input  wire                                 clk,
  input  wire                                 rstn,
  input  wire                                 op_valid,
  input  core_if_pkg::mem_op_e                op_type,
  input  wire  [core_if_pkg::paddr_w-1:0]     op_addr,
  input  wire  [core_if_pkg::dword_w-1:0]     op_wdata,
  input  wire  [core_if_pkg::mask_w-1:0]      op_mask,
  input  wire                                 flush,
  output logic                                busy,
  output logic                                done,
  output logic [core_if_pkg::dword_w-1:0]     rdata,
  output logic                                ex_re,
  output logic                                ex_we,
  output logic [core_if_pkg::paddr_w-1:0]     ex_addr,
  output logic [core_if_pkg::dword_w-1:0]     ex_wdata,
  output logic [core_if_pkg::mask_w-1:0]      ex_mask,
  input  wire                                 dc_valid,
  input  wire  [core_if_pkg::dword_w-1:0]     dc_rdata
);

  typedef enum logic {
    MS_IDLE,
    MS_WAIT
  } ms_state_e;

  ms_state_e            state;
  core_if_pkg::mem_op_e type_q;
  logic                 accept;

  assign accept = (state == MS_IDLE) && op_valid;

  always_ff @(posedge clk) begin
    if (!rstn) begin
      state <= MS_IDLE;
      done  <= 1'b0;
    end else begin
      done <= 1'b0;
      case (state)
        MS_IDLE: begin
          if (op_valid) begin
            state <= MS_WAIT;
          end
        end
        MS_WAIT: begin
          // Flush wins over a completion in the same cycle
          if (flush) begin
            state <= MS_IDLE;
          end else if (dc_valid) begin
            state <= MS_IDLE;
            done  <= 1'b1;
          end
        end
        default: state <= MS_IDLE;
      endcase
    end
  end

  // Holding registers for the access in flight
  always_ff @(posedge clk) begin
    if (accept) begin
      type_q   <= op_type;
      ex_addr  <= op_addr;
      ex_wdata <= op_wdata;
      ex_mask  <= op_mask;
    end
  end

  always_ff @(posedge clk) begin
    if ((state == MS_WAIT) && dc_valid) begin
      rdata <= dc_rdata;
    end
  end

  assign busy  = (state == MS_WAIT);
  assign ex_re = busy && (type_q == core_if_pkg::MEM_LOAD);
  assign ex_we = busy && (type_q == core_if_pkg::MEM_STORE);

  // Only one operation at a time
  a_no_op_while_busy: assert property (
    @(posedge clk) disable iff (!rstn)
    op_valid |-> !busy
  );

endmodule

`default_nettype wire

//--- design/uncached_bypass.sv
// Uncached bypass between the memory stage and the L2 port.
// Turns the held core access into one 256-bit line request, places store data
// in its lane and extracts the addressed lane from the line response.

`timescale 1ns/100ps
`default_nettype none

module uncached_bypass (
  input  wire                                  clk,
  input  wire                                  rstn,
  input  wire                                  ex_re,
  input  wire                                  ex_we,
  input  wire  [core_if_pkg::paddr_w-1:0]      ex_addr,
  input  wire  [core_if_pkg::dword_w-1:0]      ex_wdata,
  input  wire  [core_if_pkg::mask_w-1:0]       ex_mask,
  input  wire                                  flush,
  output logic                                 dc_valid,
  output logic [core_if_pkg::dword_w-1:0]      dc_rdata,
  output logic                                 req_valid,
  input  wire                                  req_ready,
  output l2_if_pkg::req_type_e                 req_type,
  output logic [core_if_pkg::paddr_w-1:0]      req_paddr,
  output logic [l2_if_pkg::line_w-1:0]         req_data,
  output logic [l2_if_pkg::line_mask_w-1:0]    req_mask,
  input  wire                                  resp_valid,
  input  wire  [l2_if_pkg::line_w-1:0]         resp_data
);

  logic                         sent;
  logic                         drop;
  logic                         xfer;
  logic [l2_if_pkg::lane_w-1:0] lane;
  logic [l2_if_pkg::lane_w-1:0] lane_q;

  // Doubleword lane inside the line
  assign lane = ex_addr[l2_if_pkg::line_ofs_w-1 -: l2_if_pkg::lane_w];

  // One request per held access, none while one is outstanding
  assign req_valid = (ex_re | ex_we) & ~sent;
  assign xfer      = req_valid & req_ready;

  // Line-aligned request address
  assign req_paddr = {ex_addr[core_if_pkg::paddr_w-1:l2_if_pkg::line_ofs_w],
                      {l2_if_pkg::line_ofs_w{1'b0}}};

  assign req_type = (ex_re & ~ex_we) ? l2_if_pkg::REQ_READ : l2_if_pkg::REQ_WRITE;

  // Store data and mask go in the addressed lane, other lanes stay zero
  always_comb begin
    req_data = '0;
    req_mask = '0;
    req_data[lane*core_if_pkg::dword_w +: core_if_pkg::dword_w] = ex_wdata;
    req_mask[lane*core_if_pkg::mask_w +: core_if_pkg::mask_w]   = ex_mask;
  end

  always_ff @(posedge clk) begin
    if (!rstn) begin
      sent <= 1'b0;
    end else if (xfer) begin
      sent <= 1'b1;
    end else if (resp_valid) begin
      sent <= 1'b0;
    end
  end

  // Lane used for extraction is the one of the issued request
  always_ff @(posedge clk) begin
    if (xfer) begin
      lane_q <= lane;
    end
  end

  // A flush while a request is in flight throws its response away
  always_ff @(posedge clk) begin
    if (!rstn) begin
      drop <= 1'b0;
    end else if (resp_valid) begin
      drop <= 1'b0;
    end else if (flush && (sent || xfer)) begin
      drop <= 1'b1;
    end
  end

  assign dc_valid = resp_valid & ~drop;
  assign dc_rdata = resp_data[lane_q*core_if_pkg::dword_w +: core_if_pkg::dword_w];

  // Completions only go to an access that is still held
  a_resp_to_held_access: assert property (
    @(posedge clk) disable iff (!rstn)
    dc_valid |-> (ex_re || ex_we)
  );

  // The L2 side only answers requests that were issued
  a_resp_expected: assert property (
    @(posedge clk) disable iff (!rstn)
    resp_valid |-> sent
  );

endmodule

`default_nettype wire

//--- design/l2_line_mem.sv
// Line-organized L2 memory model for running the data path on its own.
// Applies masked line writes on transfer and answers every request with the
// addressed line after L2_LATENCY cycles. One request at a time.

`timescale 1ns/100ps
`default_nettype none

module l2_line_mem #(
  parameter int L2_LATENCY = 4,
  parameter int L2_LINES   = 64
) (
  input  wire                                  clk,
  input  wire                                  rstn,
  input  wire                                  req_valid,
  output logic                                 req_ready,
  input  l2_if_pkg::req_type_e                 req_type,
  input  wire  [core_if_pkg::paddr_w-1:0]      req_paddr,
  input  wire  [l2_if_pkg::line_w-1:0]         req_data,
  input  wire  [l2_if_pkg::line_mask_w-1:0]    req_mask,
  output logic                                 resp_valid,
  output logic [l2_if_pkg::line_w-1:0]         resp_data
);

  localparam int IDX_W = (L2_LINES > 1) ? $clog2(L2_LINES) : 1;
  localparam int CNT_W = (L2_LATENCY > 1) ? $clog2(L2_LATENCY) : 1;
  localparam int NUM_W = core_if_pkg::paddr_w - l2_if_pkg::line_ofs_w;

  typedef enum logic {
    L2_IDLE,
    L2_BUSY
  } l2_state_e;

  l2_state_e                    state;
  logic [l2_if_pkg::line_w-1:0] lines [L2_LINES];
  logic [CNT_W-1:0]             cnt;
  logic [NUM_W-1:0]             line_num;
  logic [IDX_W-1:0]             idx;
  logic [IDX_W-1:0]             idx_q;
  logic                         xfer;

  assign req_ready = (state == L2_IDLE);
  assign xfer      = req_valid & req_ready;

  // Line index wraps modulo the model depth, so addresses alias
  assign line_num = req_paddr[core_if_pkg::paddr_w-1:l2_if_pkg::line_ofs_w];
  assign idx      = IDX_W'(line_num % L2_LINES);

  always_ff @(posedge clk) begin
    if (!rstn) begin
      state      <= L2_IDLE;
      cnt        <= '0;
      resp_valid <= 1'b0;
    end else begin
      resp_valid <= 1'b0;
      case (state)
        L2_IDLE: begin
          if (xfer) begin
            state <= L2_BUSY;
            cnt   <= CNT_W'(L2_LATENCY - 1);
          end
        end
        L2_BUSY: begin
          if (cnt == '0) begin
            state      <= L2_IDLE;
            resp_valid <= 1'b1;
          end else begin
            cnt <= cnt - 1'b1;
          end
        end
        default: state <= L2_IDLE;
      endcase
    end
  end

  // Line array, written byte by byte in the transfer cycle
  always_ff @(posedge clk) begin
    if (!rstn) begin
      for (int i = 0; i < L2_LINES; i++) begin
        lines[i] <= '0;
      end
    end else if (xfer && (req_type == l2_if_pkg::REQ_WRITE)) begin
      for (int b = 0; b < l2_if_pkg::line_mask_w; b++) begin
        if (req_mask[b]) begin
          lines[idx][8*b +: 8] <= req_data[8*b +: 8];
        end
      end
    end
  end

  // Response carries the line as it is after any write
  always_ff @(posedge clk) begin
    if (xfer) begin
      idx_q <= idx;
    end
    if ((state == L2_BUSY) && (cnt == '0)) begin
      resp_data <= lines[idx_q];
    end
  end

  // Nothing transfers during the busy window after a transfer
  a_no_xfer_while_busy: assert property (
    @(posedge clk) disable iff (!rstn)
    xfer |=> !xfer [*L2_LATENCY]
  );

endmodule

`default_nettype wire

//--- design/dmem_subsys_top.sv
// Top level of the uncached data memory subsystem.
// Memory stage, uncached bypass and L2 line model connected by wires;
// L2_LATENCY and L2_LINES are set here and passed to the L2 model.

`timescale 1ns/100ps
`default_nettype none

module dmem_subsys_top #(
  parameter int L2_LATENCY = 4,
  parameter int L2_LINES   = 64
) (
  input  wire                                 clk,
  input  wire                                 rstn,
  input  wire                                 op_valid,
  input  core_if_pkg::mem_op_e                op_type,
  input  wire  [core_if_pkg::paddr_w-1:0]     op_addr,
  input  wire  [core_if_pkg::dword_w-1:0]     op_wdata,
  input  wire  [core_if_pkg::mask_w-1:0]      op_mask,
  input  wire                                 flush,
  output logic                                busy,
  output logic                                done,
  output logic [core_if_pkg::dword_w-1:0]     rdata
);

  // Memory stage to bypass
  logic                              ex_re;
  logic                              ex_we;
  logic [core_if_pkg::paddr_w-1:0]   ex_addr;
  logic [core_if_pkg::dword_w-1:0]   ex_wdata;
  logic [core_if_pkg::mask_w-1:0]    ex_mask;
  logic                              dc_valid;
  logic [core_if_pkg::dword_w-1:0]   dc_rdata;

  // Bypass to L2 model
  logic                              req_valid;
  logic                              req_ready;
  l2_if_pkg::req_type_e              req_type;
  logic [core_if_pkg::paddr_w-1:0]   req_paddr;
  logic [l2_if_pkg::line_w-1:0]      req_data;
  logic [l2_if_pkg::line_mask_w-1:0] req_mask;
  logic                              resp_valid;
  logic [l2_if_pkg::line_w-1:0]      resp_data;

  mem_stage u_mem_stage (
    .clk      (clk),      .rstn     (rstn),
    .op_valid (op_valid), .op_type  (op_type),  .op_addr  (op_addr),
    .op_wdata (op_wdata), .op_mask  (op_mask),  .flush    (flush),
    .busy     (busy),     .done     (done),     .rdata    (rdata),
    .ex_re    (ex_re),    .ex_we    (ex_we),    .ex_addr  (ex_addr),
    .ex_wdata (ex_wdata), .ex_mask  (ex_mask),
    .dc_valid (dc_valid), .dc_rdata (dc_rdata)
  );

  uncached_bypass u_bypass (
    .clk        (clk),        .rstn      (rstn),
    .ex_re      (ex_re),      .ex_we     (ex_we),     .ex_addr   (ex_addr),
    .ex_wdata   (ex_wdata),   .ex_mask   (ex_mask),   .flush     (flush),
    .dc_valid   (dc_valid),   .dc_rdata  (dc_rdata),
    .req_valid  (req_valid),  .req_ready (req_ready), .req_type  (req_type),
    .req_paddr  (req_paddr),  .req_data  (req_data),  .req_mask  (req_mask),
    .resp_valid (resp_valid), .resp_data (resp_data)
  );

  l2_line_mem #(
    .L2_LATENCY (L2_LATENCY),
    .L2_LINES   (L2_LINES)
  ) u_l2 (
    .clk        (clk),        .rstn      (rstn),
    .req_valid  (req_valid),  .req_ready (req_ready), .req_type  (req_type),
    .req_paddr  (req_paddr),  .req_data  (req_data),  .req_mask  (req_mask),
    .resp_valid (resp_valid), .resp_data (resp_data)
  );

endmodule

`default_nettype wire

//--- test/tb_checker.sv
// Checker for the uncached data path testbench.
// Watches the DUT ports, keeps a byte shadow of the L2 contents and checks
// load data, done latency, idle outputs after reset and the done count.

`timescale 1ns/100ps
`default_nettype none

module tb_checker #(
  parameter int L2_LATENCY = 4,
  parameter int L2_LINES   = 64
) (
  input  wire                              clk,
  input  wire                              rstn,
  input  wire                              op_valid,
  input  core_if_pkg::mem_op_e             op_type,
  input  wire [core_if_pkg::paddr_w-1:0]   op_addr,
  input  wire [core_if_pkg::dword_w-1:0]   op_wdata,
  input  wire [core_if_pkg::mask_w-1:0]    op_mask,
  input  wire                              flush,
  input  wire                              busy,
  input  wire                              done,
  input  wire [core_if_pkg::dword_w-1:0]   rdata,
  input  wire                              finished,
  output int                               error_count,
  output int                               op_count,
  output int                               done_count,
  output int                               load_checks
);

  localparam int LINE_BYTES = l2_if_pkg::line_w / 8;

  // Byte image of every L2 line
  logic [7:0]                      shadow [L2_LINES][LINE_BYTES];
  logic [core_if_pkg::dword_w-1:0] expected;
  int                              cycle;
  int                              accept_cycle;
  int                              flush_count;
  int                              idx;
  int                              base;
  bit                              pending;
  bit                              pending_load;
  bit                              any_accepted;
  bit                              flush_seen;
  bit                              final_done;

  // Line index wraps modulo the model depth
  function automatic int line_index(input logic [core_if_pkg::paddr_w-1:0] addr);
    return int'((addr >> l2_if_pkg::line_ofs_w) % L2_LINES);
  endfunction

  function automatic logic [core_if_pkg::dword_w-1:0] shadow_dword(
    input logic [core_if_pkg::paddr_w-1:0] addr
  );
    logic [core_if_pkg::dword_w-1:0] value;
    int                              line;
    int                              first;
    line  = line_index(addr);
    first = int'(addr[4:3]) * core_if_pkg::mask_w;
    for (int b = 0; b < core_if_pkg::mask_w; b++) begin
      value[8*b +: 8] = shadow[line][first + b];
    end
    return value;
  endfunction

  always @(posedge clk) begin
    if (!rstn) begin
      for (int i = 0; i < L2_LINES; i++) begin
        for (int b = 0; b < LINE_BYTES; b++) begin
          shadow[i][b] = 8'h00;
        end
      end
      pending    = 1'b0;
      flush_seen = 1'b0;
    end else begin
      cycle++;
      // Outputs at rest until the first operation
      if (!any_accepted && busy) begin
        error_count++;
        $display("[FAIL] t=%0d ns busy expected 0 actual %b", $time, busy);
      end
      if (!any_accepted && done) begin
        error_count++;
        $display("[FAIL] t=%0d ns done expected 0 actual %b", $time, done);
      end
      if (done) begin
        done_count++;
        if (!pending) begin
          error_count++;
          $display("Extra done pulse at %0d ns with no operation waiting for it", $time);
        end else begin
          if (cycle - accept_cycle != L2_LATENCY + 3) begin
            error_count++;
            $display("[FAIL] t=%0d ns done latency expected %0d actual %0d",
                     $time, L2_LATENCY + 3, cycle - accept_cycle);
          end
          if (pending_load) begin
            load_checks++;
            if (rdata !== expected) begin
              error_count++;
              $display("[FAIL] t=%0d ns rdata expected %h actual %h", $time, expected, rdata);
            end
          end
          pending = 1'b0;
        end
      end
      // busy must be gone one cycle after a flush
      if (flush_seen && busy) begin
        error_count++;
        $display("[FAIL] t=%0d ns busy expected 0 actual %b", $time, busy);
      end
      flush_seen = 1'b0;
      if (flush && busy && pending) begin
        pending    = 1'b0;
        flush_seen = 1'b1;
        flush_count++;
      end
      if (op_valid && !busy) begin
        if (pending) begin
          error_count++;
          $display("Done pulse missing for the operation accepted at cycle %0d", accept_cycle);
        end
        any_accepted = 1'b1;
        op_count++;
        pending      = 1'b1;
        accept_cycle = cycle;
        pending_load = (op_type == core_if_pkg::MEM_LOAD);
        if (pending_load) begin
          expected = shadow_dword(op_addr);
        end else begin
          // Stores reach memory even when flushed later
          idx  = line_index(op_addr);
          base = int'(op_addr[4:3]) * core_if_pkg::mask_w;
          for (int b = 0; b < core_if_pkg::mask_w; b++) begin
            if (op_mask[b]) begin
              shadow[idx][base + b] = op_wdata[8*b +: 8];
            end
          end
        end
      end
      if (finished && !final_done) begin
        final_done = 1'b1;
        if (done_count != op_count - flush_count) begin
          error_count++;
          $display("Expected %0d done pulses for operations not flushed, saw %0d",
                   op_count - flush_count, done_count);
        end
      end
    end
  end

endmodule

`default_nettype wire

//--- test/tb_top.sv
// Testbench top for the uncached data path.
// Runs a table of loads and stores through the DUT, some of them flushed,
// and prints a summary once the table is done.

`timescale 1ns/100ps
`default_nettype none

module tb_top;

  localparam int L2_LATENCY = 4;
  localparam int L2_LINES   = 64;
  localparam int CLK_PERIOD = 40;

  logic                            clk;
  logic                            rstn;
  logic                            op_valid;
  core_if_pkg::mem_op_e            op_type;
  logic [core_if_pkg::paddr_w-1:0] op_addr;
  logic [core_if_pkg::dword_w-1:0] op_wdata;
  logic [core_if_pkg::mask_w-1:0]  op_mask;
  logic                            flush;
  logic                            busy;
  logic                            done;
  logic [core_if_pkg::dword_w-1:0] rdata;
  logic                            finished;
  int                              error_count;
  int                              op_count;
  int                              done_count;
  int                              load_checks;
  bit                              table_ready;

  // Operation table, one entry per row
  core_if_pkg::mem_op_e            row_type [$];
  logic [core_if_pkg::paddr_w-1:0] row_addr [$];
  logic [core_if_pkg::dword_w-1:0] row_data [$];
  logic [core_if_pkg::mask_w-1:0]  row_mask [$];
  bit                              row_flush [$];
  int                              row_gap [$];

  dmem_subsys_top #(
    .L2_LATENCY (L2_LATENCY),
    .L2_LINES   (L2_LINES)
  ) dut (
    .clk (clk), .rstn (rstn), .op_valid (op_valid), .op_type (op_type),
    .op_addr (op_addr), .op_wdata (op_wdata), .op_mask (op_mask), .flush (flush),
    .busy (busy), .done (done), .rdata (rdata)
  );

  tb_checker #(
    .L2_LATENCY (L2_LATENCY),
    .L2_LINES   (L2_LINES)
  ) u_checker (
    .clk (clk), .rstn (rstn), .op_valid (op_valid), .op_type (op_type),
    .op_addr (op_addr), .op_wdata (op_wdata), .op_mask (op_mask), .flush (flush),
    .busy (busy), .done (done), .rdata (rdata), .finished (finished),
    .error_count (error_count), .op_count (op_count), .done_count (done_count),
    .load_checks (load_checks)
  );

  always #(CLK_PERIOD / 2) clk = ~clk;

  task automatic add_row(input core_if_pkg::mem_op_e t, input logic [39:0] a,
                         input logic [63:0] d, input logic [7:0] m,
                         input bit f, input int g);
    row_type.push_back(t);
    row_addr.push_back(a);
    row_data.push_back(d);
    row_mask.push_back(m);
    row_flush.push_back(f);
    row_gap.push_back(g);
  endtask

  task automatic load_table();
    // Four lanes of line 0x1000, then overwrite one lane
    add_row(core_if_pkg::MEM_STORE, 40'h00_0000_1000, 64'h0123_4567_89ab_cdef, 8'hff, 0, 1);
    add_row(core_if_pkg::MEM_STORE, 40'h00_0000_1008, 64'hfedc_ba98_7654_3210, 8'hff, 0, 0);
    add_row(core_if_pkg::MEM_STORE, 40'h00_0000_1010, 64'ha5a5_5a5a_0f0f_f0f0, 8'hff, 0, 2);
    add_row(core_if_pkg::MEM_STORE, 40'h00_0000_1018, 64'hdead_beef_cafe_f00d, 8'hff, 0, 0);
    add_row(core_if_pkg::MEM_LOAD,  40'h00_0000_1000, 64'h0, 8'h00, 0, 1);
    add_row(core_if_pkg::MEM_LOAD,  40'h00_0000_1008, 64'h0, 8'h00, 0, 0);
    add_row(core_if_pkg::MEM_LOAD,  40'h00_0000_1010, 64'h0, 8'h00, 0, 3);
    add_row(core_if_pkg::MEM_LOAD,  40'h00_0000_1018, 64'h0, 8'h00, 0, 0);
    add_row(core_if_pkg::MEM_STORE, 40'h00_0000_1008, 64'h1357_9bdf_2468_ace0, 8'hff, 0, 1);
    add_row(core_if_pkg::MEM_LOAD,  40'h00_0000_1000, 64'h0, 8'h00, 0, 0);
    add_row(core_if_pkg::MEM_LOAD,  40'h00_0000_1008, 64'h0, 8'h00, 0, 2);
    add_row(core_if_pkg::MEM_LOAD,  40'h00_0000_1018, 64'h0, 8'h00, 0, 0);
    // Byte merge inside one doubleword
    add_row(core_if_pkg::MEM_STORE, 40'h00_0000_2040, 64'haaaa_aaaa_aaaa_aaaa, 8'hff, 0, 0);
    add_row(core_if_pkg::MEM_STORE, 40'h00_0000_2040, 64'h8877_6655_4433_2211, 8'h0f, 0, 1);
    add_row(core_if_pkg::MEM_STORE, 40'h00_0000_2040, 64'h0102_0304_0506_0708, 8'hc0, 0, 0);
    add_row(core_if_pkg::MEM_STORE, 40'h00_0000_2040, 64'hffee_ddcc_bbaa_9988, 8'h24, 0, 2);
    add_row(core_if_pkg::MEM_LOAD,  40'h00_0000_2040, 64'h0, 8'h00, 0, 0);
    // Aliasing lines 0x0060 and 0x0860, plus never written lines
    add_row(core_if_pkg::MEM_STORE, 40'h00_0000_0060, 64'hcafe_0000_beef_1111, 8'hff, 0, 1);
    add_row(core_if_pkg::MEM_LOAD,  40'h00_0000_0860, 64'h0, 8'h00, 0, 0);
    add_row(core_if_pkg::MEM_STORE, 40'h00_0000_0868, 64'h7777_8888_9999_aaaa, 8'hf0, 0, 0);
    add_row(core_if_pkg::MEM_LOAD,  40'h00_0000_0068, 64'h0, 8'h00, 0, 3);
    add_row(core_if_pkg::MEM_LOAD,  40'h00_0000_3fe0, 64'h0, 8'h00, 0, 0);
    add_row(core_if_pkg::MEM_LOAD,  40'hff_ffff_fff8, 64'h0, 8'h00, 0, 1);
    // Flushed store still lands in memory, flushed load gives nothing
    add_row(core_if_pkg::MEM_STORE, 40'h00_0000_1018, 64'h0bad_f00d_1234_5678, 8'hff, 1, 5);
    add_row(core_if_pkg::MEM_LOAD,  40'h00_0000_1018, 64'h0, 8'h00, 0, 0);
    add_row(core_if_pkg::MEM_LOAD,  40'h00_0000_2040, 64'h0, 8'h00, 1, 5);
    add_row(core_if_pkg::MEM_LOAD,  40'h00_0000_1010, 64'h0, 8'h00, 0, 1);
    add_row(core_if_pkg::MEM_STORE, 40'h00_0000_2048, 64'h9abc_def0_1122_3344, 8'h81, 0, 0);
    add_row(core_if_pkg::MEM_LOAD,  40'h00_0000_2048, 64'h0, 8'h00, 0, 0);
  endtask

  // One row: drive, accept, optional flush, wait for idle, then the gap
  task automatic run_row(input int r);
    @(posedge clk);
    #1;
    op_valid = 1'b1;
    op_type  = row_type[r];
    op_addr  = row_addr[r];
    op_wdata = row_data[r];
    op_mask  = row_mask[r];
    @(posedge clk);
    #1;
    op_valid = 1'b0;
    if (row_flush[r]) begin
      @(posedge clk);
      #1;
      flush = 1'b1;
      @(posedge clk);
      #1;
      flush = 1'b0;
    end
    while (busy) begin
      @(posedge clk);
      #1;
    end
    repeat (row_gap[r]) @(posedge clk);
  endtask

  initial begin
    clk      = 1'b0;
    rstn     = 1'b0;
    op_valid = 1'b0;
    op_type  = core_if_pkg::MEM_LOAD;
    op_addr  = '0;
    op_wdata = '0;
    op_mask  = '0;
    flush    = 1'b0;
    finished = 1'b0;
    load_table();
    table_ready = 1'b1;
    repeat (16) @(posedge clk);
    #1;
    rstn = 1'b1;
    // Idle stretch so busy and done are seen at rest
    repeat (4) @(posedge clk);
    foreach (row_addr[r]) begin
      run_row(r);
    end
    repeat (4) @(posedge clk);
    #1;
    finished = 1'b1;
    repeat (2) @(posedge clk);
    #1;
    $display("Summary: %0d operations, %0d done pulses, %0d load checks, %0d errors",
             op_count, done_count, load_checks, error_count);
    if (error_count == 0) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

  // Watchdog sized from the table length
  initial begin
    wait (table_ready);
    #((row_addr.size() * (L2_LATENCY + 10) + 40) * CLK_PERIOD);
    $display("Timeout: the operation table did not finish in the expected time");
    $display("tests failed");
    $finish;
  end

endmodule

`default_nettype wire

//--- list.f
design/core_if_pkg.sv
design/l2_if_pkg.sv
design/mem_stage.sv
design/uncached_bypass.sv
design/l2_line_mem.sv
design/dmem_subsys_top.sv
test/tb_checker.sv
test/tb_top.sv

//--- run.sh
#!/bin/sh
# Build and run the uncached data path testbench with Verilator.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 -f list.f --top-module tb_top -o sim_tb_top
status=$?
if [ $status -ne 0 ]; then
  echo "Verilator build failed with status $status"
  exit 1
fi

output=$(./obj_dir/sim_tb_top)
status=$?
printf '%s\n' "$output"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if printf '%s\n' "$output" | grep -qx "all tests passed"; then
  exit 0
fi
echo "Pass message not found in simulation output"
exit 1
